// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	localparam int XLEN = 32;         // data and pc width
	localparam int MULDIV_STEPS = 32; // iterations per mul or div

	// instruction opcode, bits 31..27
	typedef enum logic [4:0] {
		OP_RTYPE = 5'd0,
		OP_J     = 5'd1,
		OP_BNE   = 5'd2,
		OP_JAL   = 5'd3,
		OP_JR    = 5'd4,
		OP_ADDI  = 5'd5,
		OP_BLT   = 5'd6,
		OP_SW    = 5'd7,
		OP_LW    = 5'd8,
		OP_BEQ   = 5'd9,
		OP_SETX  = 5'd21,
		OP_BEX   = 5'd22
	} opcode_e;

	// r-type function field, bits 6..2
	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_AND = 5'd2,
		ALU_OR  = 5'd3,
		ALU_SLL = 5'd4,
		ALU_SRA = 5'd5,
		ALU_MUL = 5'd6,
		ALU_DIV = 5'd7
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_BNE,
		BR_BLT,
		BR_BEQ,
		BR_BEX,
		BR_JUMP, // j and jal
		BR_JR
	} branch_kind_e;

	// value written to the result on an exception
	localparam logic [2:0] EXC_NONE = 3'd0;
	localparam logic [2:0] EXC_ADD  = 3'd1;
	localparam logic [2:0] EXC_ADDI = 3'd2;
	localparam logic [2:0] EXC_SUB  = 3'd3;
	localparam logic [2:0] EXC_MUL  = 3'd4;
	localparam logic [2:0] EXC_DIV  = 3'd5;

endpackage

// ==== rtl/insn_decode.sv ====
`timescale 1ns/100ps

module insn_decode (
	input  logic [isa_pkg::XLEN-1:0] i_insn,
	output isa_pkg::alu_op_e         o_alu_op,
	output logic                     o_use_imm,
	output logic                     o_zero_b,
	output isa_pkg::branch_kind_e    o_branch_kind,
	output logic                     o_link,
	output logic                     o_setx,
	output logic                     o_is_muldiv,
	output logic [2:0]               o_exc_code
);
	import isa_pkg::*;

	opcode_e opcode;
	alu_op_e func;

	assign opcode = opcode_e'(i_insn[31:27]);
	assign func = alu_op_e'(i_insn[6:2]);

	always_comb begin
		o_alu_op = ALU_ADD;
		o_use_imm = 1'b0;
		o_zero_b = 1'b0;
		o_branch_kind = BR_NONE;
		o_link = 1'b0;
		o_setx = 1'b0;
		o_is_muldiv = 1'b0;
		o_exc_code = EXC_NONE;
		case (opcode)
			OP_RTYPE: begin
				o_alu_op = func; // function field straight through
				o_is_muldiv = (func == ALU_MUL) || (func == ALU_DIV);
				case (func)
					ALU_ADD: o_exc_code = EXC_ADD;
					ALU_SUB: o_exc_code = EXC_SUB;
					ALU_MUL: o_exc_code = EXC_MUL;
					ALU_DIV: o_exc_code = EXC_DIV;
					default: o_exc_code = EXC_NONE;
				endcase
			end
			OP_ADDI: begin
				o_use_imm = 1'b1;
				o_exc_code = EXC_ADDI;
			end
			OP_LW, OP_SW: o_use_imm = 1'b1; // address is rs + imm
			OP_BNE: begin
				o_alu_op = ALU_SUB;
				o_branch_kind = BR_BNE;
			end
			OP_BLT: begin
				o_alu_op = ALU_SUB;
				o_branch_kind = BR_BLT;
			end
			OP_BEQ: begin
				o_alu_op = ALU_SUB;
				o_branch_kind = BR_BEQ;
			end
			OP_BEX: begin
				o_alu_op = ALU_SUB;
				o_zero_b = 1'b1; // compare rstatus against zero
				o_branch_kind = BR_BEX;
			end
			OP_J: o_branch_kind = BR_JUMP;
			OP_JAL: begin
				o_branch_kind = BR_JUMP;
				o_link = 1'b1;
			end
			OP_JR: o_branch_kind = BR_JR;
			OP_SETX: o_setx = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu (
	input  logic [isa_pkg::XLEN-1:0] i_a,
	input  logic [isa_pkg::XLEN-1:0] i_b,
	input  isa_pkg::alu_op_e         i_op,
	input  logic [4:0]               i_shamt,
	output logic [isa_pkg::XLEN-1:0] o_result,
	output logic                     o_overflow,
	output logic                     o_not_equal,
	output logic                     o_less_than
);
	import isa_pkg::*;

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic            add_ovf;
	logic            sub_ovf;

	assign sum = i_a + i_b;
	assign diff = i_a - i_b;

	// operands of equal sign, result of the other sign
	assign add_ovf = (i_a[XLEN-1] == i_b[XLEN-1]) && (sum[XLEN-1] != i_a[XLEN-1]);
	assign sub_ovf = (i_a[XLEN-1] != i_b[XLEN-1]) && (diff[XLEN-1] != i_a[XLEN-1]);

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = sum;
			ALU_SUB: o_result = diff;
			ALU_AND: o_result = i_a & i_b;
			ALU_OR:  o_result = i_a | i_b;
			ALU_SLL: o_result = i_a << i_shamt;
			ALU_SRA: o_result = $unsigned($signed(i_a) >>> i_shamt);
			default: o_result = '0; // mul and div come from muldiv
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ADD: o_overflow = add_ovf;
			ALU_SUB: o_overflow = sub_ovf;
			default: o_overflow = 1'b0;
		endcase
	end

	assign o_not_equal = (i_a != i_b);
	assign o_less_than = ($signed(i_a) < $signed(i_b)); // signed compare

endmodule

// ==== rtl/muldiv.sv ====
`timescale 1ns/100ps

module muldiv (
	input  logic                     clock,
	input  logic                     i_rst_n,
	input  logic                     i_start,
	input  logic                     i_is_div,
	input  logic [isa_pkg::XLEN-1:0] i_a,
	input  logic [isa_pkg::XLEN-1:0] i_b,
	output logic [isa_pkg::XLEN-1:0] o_result,
	output logic                     o_overflow,
	output logic                     o_div_zero,
	output logic                     o_done
);
	import isa_pkg::*;

	logic [$clog2(MULDIV_STEPS)-1:0] step;
	logic                            busy;
	logic                            done_q;
	logic                            is_div_q;
	logic                            neg_q;
	logic                            b_zero_q;
	logic [XLEN-1:0]                 abs_a;
	logic [XLEN-1:0]                 abs_b;
	logic [XLEN-1:0]                 opnd_q;   // multiplicand or divisor
	logic [XLEN-1:0]                 acc;      // upper product or remainder
	logic [XLEN-1:0]                 lo;       // multiplier, then quotient
	logic [XLEN:0]                   add_sum;
	logic [XLEN:0]                   rem_shift;
	logic [2*XLEN-1:0]               prod_s;
	logic [XLEN-1:0]                 quot_s;

	assign abs_a = i_a[XLEN-1] ? -i_a : i_a;
	assign abs_b = i_b[XLEN-1] ? -i_b : i_b;

	assign add_sum = {1'b0, acc} + (lo[0] ? {1'b0, opnd_q} : '0);
	assign rem_shift = {acc, lo[XLEN-1]};

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			done_q <= 1'b0;
			step <= '0;
			is_div_q <= 1'b0;
			neg_q <= 1'b0;
			b_zero_q <= 1'b0;
		end else if (i_start) begin
			busy <= 1'b1;
			done_q <= 1'b0;
			step <= '0;
			is_div_q <= i_is_div;
			neg_q <= i_a[XLEN-1] ^ i_b[XLEN-1]; // sign applied at the end
			b_zero_q <= (i_b == '0);
		end else if (busy) begin
			step <= step + 1'b1;
			if (step == $bits(step)'(MULDIV_STEPS - 1)) begin
				busy <= 1'b0;
				done_q <= 1'b1; // held until next start
			end
		end
	end

	always_ff @(posedge clock) begin
		if (i_start) begin
			opnd_q <= i_is_div ? abs_b : abs_a;
			lo <= i_is_div ? abs_a : abs_b;
			acc <= '0;
		end else if (busy) begin
			if (is_div_q) begin
				// restoring step, one quotient bit per cycle
				if (rem_shift >= {1'b0, opnd_q}) begin
					acc <= rem_shift[XLEN-1:0] - opnd_q;
					lo <= {lo[XLEN-2:0], 1'b1};
				end else begin
					acc <= rem_shift[XLEN-1:0];
					lo <= {lo[XLEN-2:0], 1'b0};
				end
			end else begin
				acc <= add_sum[XLEN:1]; // shift-add, product moves right
				lo <= {add_sum[0], lo[XLEN-1:1]};
			end
		end
	end

	assign prod_s = neg_q ? -{acc, lo} : {acc, lo};
	assign quot_s = neg_q ? -lo : lo; // truncates toward zero

	assign o_result = is_div_q ? quot_s : prod_s[XLEN-1:0];
	assign o_overflow = !is_div_q && (prod_s[2*XLEN-1:XLEN] != {XLEN{prod_s[XLEN-1]}});
	assign o_div_zero = is_div_q && b_zero_q;
	assign o_done = done_q;

endmodule

// ==== rtl/stage_execute.sv ====
`timescale 1ns/100ps

module stage_execute (
	input  logic                     clock,
	input  logic                     i_rst_n,
	input  logic                     i_start,
	input  logic [isa_pkg::XLEN-1:0] i_insn,
	input  logic [isa_pkg::XLEN-1:0] i_operand_a,
	input  logic [isa_pkg::XLEN-1:0] i_operand_b,
	input  logic [isa_pkg::XLEN-1:0] i_pc,
	input  logic                     i_mx_bypass_a,
	input  logic                     i_wx_bypass_a,
	input  logic                     i_mx_bypass_b,
	input  logic                     i_wx_bypass_b,
	input  logic [isa_pkg::XLEN-1:0] i_xm_value,
	input  logic [isa_pkg::XLEN-1:0] i_wb_value,
	input  isa_pkg::alu_op_e         i_alu_op,
	input  logic                     i_use_imm,
	input  logic                     i_zero_b,
	input  isa_pkg::branch_kind_e    i_branch_kind,
	input  logic                     i_link,
	input  logic                     i_setx,
	input  logic                     i_is_muldiv,
	input  logic [2:0]               i_exc_code,
	output logic                     o_done,
	output logic [isa_pkg::XLEN-1:0] o_result,
	output logic [isa_pkg::XLEN-1:0] o_b_value,
	output logic                     o_write_exception,
	output logic [isa_pkg::XLEN-1:0] o_next_pc,
	output logic                     o_taken
);
	import isa_pkg::*;

	logic [XLEN-1:0] fwd_a;
	logic [XLEN-1:0] fwd_b;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] jump_target;
	logic [XLEN-1:0] pc_branch;
	logic [XLEN-1:0] branch_target;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] md_result;
	logic            alu_ovf;
	logic            not_equal;
	logic            less_than;
	logic            md_ovf;
	logic            md_div_zero;
	logic            md_done;
	logic            exc_raised;

	// mx beats wx beats the register file
	assign fwd_a = i_mx_bypass_a ? i_xm_value : (i_wx_bypass_a ? i_wb_value : i_operand_a);
	assign fwd_b = i_mx_bypass_b ? i_xm_value : (i_wx_bypass_b ? i_wb_value : i_operand_b);

	assign imm_ext = {{(XLEN-17){i_insn[16]}}, i_insn[16:0]};
	assign alu_b = i_use_imm ? imm_ext : (i_zero_b ? '0 : fwd_b);

	assign jump_target = {i_pc[XLEN-1:XLEN-5], i_insn[26:0]};
	assign pc_branch = i_pc + imm_ext; // i_pc already holds pc+1

	alu u_alu (
		.i_a         (fwd_a),
		.i_b         (alu_b),
		.i_op        (i_alu_op),
		.i_shamt     (i_insn[11:7]),
		.o_result    (alu_result),
		.o_overflow  (alu_ovf),
		.o_not_equal (not_equal),
		.o_less_than (less_than)
	);

	muldiv u_muldiv (
		.clock      (clock),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start && i_is_muldiv),
		.i_is_div   (i_alu_op == ALU_DIV),
		.i_a        (fwd_a),
		.i_b        (fwd_b),
		.o_result   (md_result),
		.o_overflow (md_ovf),
		.o_div_zero (md_div_zero),
		.o_done     (md_done)
	);

	always_comb begin
		o_taken = 1'b0;
		branch_target = jump_target;
		case (i_branch_kind)
			BR_BNE: begin
				o_taken = not_equal;
				branch_target = pc_branch;
			end
			BR_BLT: begin
				o_taken = not_equal && !less_than; // a is rs, b is rd
				branch_target = pc_branch;
			end
			BR_BEQ: begin
				o_taken = !not_equal;
				branch_target = pc_branch;
			end
			BR_BEX: o_taken = not_equal; // rstatus != 0
			BR_JUMP: o_taken = 1'b1;
			BR_JR: begin
				o_taken = 1'b1;
				branch_target = fwd_b;
			end
			default: ;
		endcase
	end

	assign o_next_pc = o_taken ? branch_target : '0;

	assign exc_raised = i_is_muldiv ? (md_ovf || md_div_zero) : alu_ovf;
	assign o_write_exception = exc_raised && (i_exc_code != EXC_NONE);

	always_comb begin
		if (i_link)
			o_result = i_pc;
		else if (o_write_exception)
			o_result = {{(XLEN-3){1'b0}}, i_exc_code};
		else if (i_setx)
			o_result = jump_target;
		else if (i_is_muldiv)
			o_result = md_result;
		else
			o_result = alu_result;
	end

	assign o_b_value = fwd_b; // store data
	assign o_done = i_is_muldiv ? md_done : 1'b1;

endmodule

// ==== rtl/result_handshake.sv ====
`timescale 1ns/100ps

module result_handshake (
	input  logic                     clock,
	input  logic                     i_rst_n,
	input  logic                     i_req,
	output logic                     o_ack,
	output logic                     o_start,
	input  logic                     i_done,
	input  logic [isa_pkg::XLEN-1:0] i_result,
	input  logic [isa_pkg::XLEN-1:0] i_b_value,
	input  logic                     i_write_exception,
	input  logic [isa_pkg::XLEN-1:0] i_next_pc,
	input  logic                     i_taken,
	output logic [isa_pkg::XLEN-1:0] o_result,
	output logic [isa_pkg::XLEN-1:0] o_b_value,
	output logic                     o_write_exception,
	output logic [isa_pkg::XLEN-1:0] o_next_pc,
	output logic                     o_taken
);

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		ACK
	} state_e;

	state_e state;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_ack <= 1'b0;
			o_start <= 1'b0;
			o_result <= '0;
			o_b_value <= '0;
			o_write_exception <= 1'b0;
			o_next_pc <= '0;
			o_taken <= 1'b0;
		end else begin
			o_start <= 1'b0; // single cycle pulse
			case (state)
				IDLE: begin
					if (i_req) begin
						state <= BUSY;
						o_start <= 1'b1;
					end
				end
				BUSY: begin
					// done from the previous op is still up during the start cycle
					if (!o_start && i_done) begin
						o_result <= i_result;
						o_b_value <= i_b_value;
						o_write_exception <= i_write_exception;
						o_next_pc <= i_next_pc;
						o_taken <= i_taken;
						o_ack <= 1'b1;
						state <= ACK;
					end
				end
				ACK: begin
					if (!i_req) begin // requester released
						o_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/exec_unit_top.sv ====
`timescale 1ns/100ps

module exec_unit_top (
	input  logic                     clock,
	input  logic                     i_rst_n,
	input  logic                     i_req,
	input  logic [isa_pkg::XLEN-1:0] i_insn,
	input  logic [isa_pkg::XLEN-1:0] i_operand_a,
	input  logic [isa_pkg::XLEN-1:0] i_operand_b,
	input  logic [isa_pkg::XLEN-1:0] i_pc,
	input  logic                     i_mx_bypass_a,
	input  logic                     i_wx_bypass_a,
	input  logic                     i_mx_bypass_b,
	input  logic                     i_wx_bypass_b,
	input  logic [isa_pkg::XLEN-1:0] i_xm_value,
	input  logic [isa_pkg::XLEN-1:0] i_wb_value,
	output logic                     o_ack,
	output logic [isa_pkg::XLEN-1:0] o_result,
	output logic [isa_pkg::XLEN-1:0] o_b_value,
	output logic                     o_write_exception,
	output logic [isa_pkg::XLEN-1:0] o_next_pc,
	output logic                     o_taken
);
	import isa_pkg::*;

	alu_op_e         alu_op;
	branch_kind_e    branch_kind;
	logic            use_imm;
	logic            zero_b;
	logic            link;
	logic            setx;
	logic            is_muldiv;
	logic [2:0]      exc_code;
	logic            start;
	logic            done;
	logic [XLEN-1:0] ex_result;
	logic [XLEN-1:0] ex_b_value;
	logic            ex_write_exception;
	logic [XLEN-1:0] ex_next_pc;
	logic            ex_taken;

	insn_decode u_decode (
		.i_insn        (i_insn),
		.o_alu_op      (alu_op),
		.o_use_imm     (use_imm),
		.o_zero_b      (zero_b),
		.o_branch_kind (branch_kind),
		.o_link        (link),
		.o_setx        (setx),
		.o_is_muldiv   (is_muldiv),
		.o_exc_code    (exc_code)
	);

	stage_execute u_execute (
		.clock             (clock),
		.i_rst_n           (i_rst_n),
		.i_start           (start),
		.i_insn            (i_insn),
		.i_operand_a       (i_operand_a),
		.i_operand_b       (i_operand_b),
		.i_pc              (i_pc),
		.i_mx_bypass_a     (i_mx_bypass_a),
		.i_wx_bypass_a     (i_wx_bypass_a),
		.i_mx_bypass_b     (i_mx_bypass_b),
		.i_wx_bypass_b     (i_wx_bypass_b),
		.i_xm_value        (i_xm_value),
		.i_wb_value        (i_wb_value),
		.i_alu_op          (alu_op),
		.i_use_imm         (use_imm),
		.i_zero_b          (zero_b),
		.i_branch_kind     (branch_kind),
		.i_link            (link),
		.i_setx            (setx),
		.i_is_muldiv       (is_muldiv),
		.i_exc_code        (exc_code),
		.o_done            (done),
		.o_result          (ex_result),
		.o_b_value         (ex_b_value),
		.o_write_exception (ex_write_exception),
		.o_next_pc         (ex_next_pc),
		.o_taken           (ex_taken)
	);

	result_handshake u_result (
		.clock             (clock),
		.i_rst_n           (i_rst_n),
		.i_req             (i_req),
		.o_ack             (o_ack),
		.o_start           (start),
		.i_done            (done),
		.i_result          (ex_result),
		.i_b_value         (ex_b_value),
		.i_write_exception (ex_write_exception),
		.i_next_pc         (ex_next_pc),
		.i_taken           (ex_taken),
		.o_result          (o_result),
		.o_b_value         (o_b_value),
		.o_write_exception (o_write_exception),
		.o_next_pc         (o_next_pc),
		.o_taken           (o_taken)
	);

endmodule

// ==== tests/exec_unit_asserts.sv ====
`timescale 1ns/100ps

module exec_unit_asserts (
	input logic                     clock,
	input logic                     i_rst_n,
	input logic                     i_req,
	input logic                     i_ack,
	input logic                     i_start,
	input logic [isa_pkg::XLEN-1:0] i_result,
	input logic [isa_pkg::XLEN-1:0] i_b_value,
	input logic                     i_write_exception,
	input logic [isa_pkg::XLEN-1:0] i_next_pc,
	input logic                     i_taken
);

	int unsigned failures = 0; // summed into the testbench total

	ack_after_req: assert property (@(posedge clock) disable iff (!i_rst_n)
		$rose(i_ack) |-> $past(i_req))
		else begin
			$error("ack rose while no request was pending");
			failures++;
		end

	ack_held: assert property (@(posedge clock) disable iff (!i_rst_n)
		(i_ack && i_req) |=> i_ack)
		else begin
			$error("ack fell while the request was still high");
			failures++;
		end

	start_pulse: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_start |=> !i_start)
		else begin
			$error("start lasted more than one cycle");
			failures++;
		end

	// registered bundle frozen for the whole ack phase
	outputs_held: assert property (@(posedge clock) disable iff (!i_rst_n)
		(i_ack && $past(i_ack)) |-> ($stable(i_result) && $stable(i_b_value)
			&& $stable(i_write_exception) && $stable(i_next_pc) && $stable(i_taken)))
		else begin
			$error("held outputs changed while ack was high");
			failures++;
		end

endmodule

// ==== tests/exec_unit_tb.sv ====
`timescale 1ns/100ps

module exec_unit_tb;
	import isa_pkg::*;

	localparam int NUM_TXN = 400;
	localparam int WATCHDOG_NS = (NUM_TXN * 40 + 8) * 8; // 40 cycles per txn plus reset
	localparam longint INT_MAX = 64'sd2147483647;
	localparam longint INT_MIN = -64'sd2147483648;

	logic            clock = 1'b0;
	logic            i_rst_n;
	logic            i_req;
	logic [XLEN-1:0] i_insn;
	logic [XLEN-1:0] i_operand_a;
	logic [XLEN-1:0] i_operand_b;
	logic [XLEN-1:0] i_pc;
	logic            i_mx_bypass_a;
	logic            i_wx_bypass_a;
	logic            i_mx_bypass_b;
	logic            i_wx_bypass_b;
	logic [XLEN-1:0] i_xm_value;
	logic [XLEN-1:0] i_wb_value;
	logic            o_ack;
	logic [XLEN-1:0] o_result;
	logic [XLEN-1:0] o_b_value;
	logic            o_write_exception;
	logic [XLEN-1:0] o_next_pc;
	logic            o_taken;

	logic [XLEN-1:0] exp_result;
	logic [XLEN-1:0] exp_b_value;
	logic [XLEN-1:0] exp_next_pc;
	logic            exp_exc;
	logic            exp_taken;
	int              mismatches = 0;
	int              other_failures = 0;
	int              total_errors;

	exec_unit_top UUT (
		.clock             (clock),
		.i_rst_n           (i_rst_n),
		.i_req             (i_req),
		.i_insn            (i_insn),
		.i_operand_a       (i_operand_a),
		.i_operand_b       (i_operand_b),
		.i_pc              (i_pc),
		.i_mx_bypass_a     (i_mx_bypass_a),
		.i_wx_bypass_a     (i_wx_bypass_a),
		.i_mx_bypass_b     (i_mx_bypass_b),
		.i_wx_bypass_b     (i_wx_bypass_b),
		.i_xm_value        (i_xm_value),
		.i_wb_value        (i_wb_value),
		.o_ack             (o_ack),
		.o_result          (o_result),
		.o_b_value         (o_b_value),
		.o_write_exception (o_write_exception),
		.o_next_pc         (o_next_pc),
		.o_taken           (o_taken)
	);

	bind exec_unit_top exec_unit_asserts u_asserts (
		.clock             (clock),
		.i_rst_n           (i_rst_n),
		.i_req             (i_req),
		.i_ack             (o_ack),
		.i_start           (start),
		.i_result          (o_result),
		.i_b_value         (o_b_value),
		.i_write_exception (o_write_exception),
		.i_next_pc         (o_next_pc),
		.i_taken           (o_taken)
	);

	always #4 clock = ~clock; // 8 ns period

	function automatic logic out_of_range(input longint s);
		return (s > INT_MAX) || (s < INT_MIN);
	endfunction

	// edge values show up far more often than plain random words
	function automatic logic [XLEN-1:0] edge_operand();
		logic [XLEN-1:0] v;
		case ($urandom_range(0, 7))
			0: v = 32'h0000_0000;
			1: v = 32'h8000_0000;
			2: v = 32'h7FFF_FFFF;
			3: v = 32'($urandom_range(1, 15));
			4: v = -32'($urandom_range(1, 15));
			5: v = 32'hFFFF_FFFF;
			default: v = $urandom();
		endcase
		return v;
	endfunction

	function automatic logic [4:0] pick_opcode();
		int unsigned r;
		r = $urandom_range(0, 99);
		if (r < 40) return OP_RTYPE; // r-type and branches dominate
		if (r < 47) return OP_ADDI;
		if (r < 52) return OP_LW;
		if (r < 57) return OP_SW;
		if (r < 65) return OP_BNE;
		if (r < 73) return OP_BLT;
		if (r < 81) return OP_BEQ;
		if (r < 88) return OP_BEX;
		if (r < 91) return OP_J;
		if (r < 94) return OP_JAL;
		if (r < 97) return OP_JR;
		return OP_SETX;
	endfunction

	task automatic compare_word(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		assert (expected === actual) else begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compare_outputs(input string tag);
		compare_word({tag, " o_result"}, exp_result, o_result);
		compare_word({tag, " o_b_value"}, exp_b_value, o_b_value);
		compare_word({tag, " o_write_exception"}, {31'b0, exp_exc}, {31'b0, o_write_exception});
		compare_word({tag, " o_next_pc"}, exp_next_pc, o_next_pc);
		compare_word({tag, " o_taken"}, {31'b0, exp_taken}, {31'b0, o_taken});
	endtask

	// reference model of one execute step with sel as {mx_a, wx_a, mx_b, wx_b}
	task automatic build_expected(input logic [XLEN-1:0] insn, input logic [XLEN-1:0] opa,
			input logic [XLEN-1:0] opb, input logic [XLEN-1:0] pc,
			input logic [XLEN-1:0] xm, input logic [XLEN-1:0] wb, input logic [3:0] sel);
		logic [XLEN-1:0] fa;
		logic [XLEN-1:0] fb;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] upper;
		logic [XLEN-1:0] target;
		logic [XLEN-1:0] value;
		logic [2:0]      code;
		logic            ovf;
		longint          wide;

		fa = sel[3] ? xm : (sel[2] ? wb : opa);
		fb = sel[1] ? xm : (sel[0] ? wb : opb);
		imm = {{15{insn[16]}}, insn[16:0]};
		upper = {pc[31:27], insn[26:0]};
		target = upper;
		value = '0;
		code = EXC_NONE;
		ovf = 1'b0;
		exp_taken = 1'b0;
		case (insn[31:27])
			OP_RTYPE: begin
				case (insn[6:2])
					ALU_ADD: begin
						value = fa + fb;
						ovf = out_of_range(longint'($signed(fa)) + longint'($signed(fb)));
						code = EXC_ADD;
					end
					ALU_SUB: begin
						value = fa - fb;
						ovf = out_of_range(longint'($signed(fa)) - longint'($signed(fb)));
						code = EXC_SUB;
					end
					ALU_AND: value = fa & fb;
					ALU_OR:  value = fa | fb;
					ALU_SLL: value = fa << insn[11:7];
					ALU_SRA: value = $unsigned($signed(fa) >>> insn[11:7]);
					ALU_MUL: begin
						wide = longint'($signed(fa)) * longint'($signed(fb));
						value = wide[31:0];
						ovf = (wide != longint'($signed(wide[31:0]))); // low word only
						code = EXC_MUL;
					end
					ALU_DIV: begin
						if (fb == '0) begin
							ovf = 1'b1;
						end else begin
							wide = longint'($signed(fa)) / longint'($signed(fb));
							value = wide[31:0]; // min int over -1 wraps back to min int
						end
						code = EXC_DIV;
					end
					default: value = '0;
				endcase
			end
			OP_ADDI: begin
				value = fa + imm;
				ovf = out_of_range(longint'($signed(fa)) + longint'($signed(imm)));
				code = EXC_ADDI;
			end
			OP_LW, OP_SW: value = fa + imm;
			OP_BNE: begin
				value = fa - fb;
				exp_taken = (fa != fb);
				target = pc + imm;
			end
			OP_BLT: begin
				value = fa - fb;
				exp_taken = ($signed(fb) < $signed(fa)); // rd below rs
				target = pc + imm;
			end
			OP_BEQ: begin
				value = fa - fb;
				exp_taken = (fa == fb);
				target = pc + imm;
			end
			OP_BEX: begin
				value = fa;
				exp_taken = (fa != '0);
			end
			OP_J: begin
				value = fa + fb;
				exp_taken = 1'b1;
			end
			OP_JAL: begin
				value = pc;
				exp_taken = 1'b1;
			end
			OP_JR: begin
				value = fa + fb;
				exp_taken = 1'b1;
				target = fb;
			end
			OP_SETX: value = upper;
			default: value = fa + fb;
		endcase
		exp_exc = ovf && (code != EXC_NONE);
		exp_result = exp_exc ? {29'b0, code} : value;
		exp_next_pc = exp_taken ? target : '0;
		exp_b_value = fb;
	endtask

	task automatic run_transaction(input int n);
		logic [XLEN-1:0] insn;
		logic [XLEN-1:0] opa;
		logic [XLEN-1:0] opb;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] xm;
		logic [XLEN-1:0] wb;
		logic [3:0]      sel;
		logic            long_op;
		int              wait_cycles;
		int              hold;
		string           tag;

		insn = $urandom();
		insn[31:27] = pick_opcode();
		case ($urandom_range(0, 3))
			0: insn[16:0] = 17'h0FFFF;
			1: insn[16:0] = 17'h10000;
			2: insn[16:0] = 17'($urandom_range(0, 7));
			default: ;
		endcase
		if (insn[31:27] == OP_RTYPE)
			insn[6:2] = 5'($urandom_range(0, 7));
		opa = edge_operand();
		opb = edge_operand();
		xm = edge_operand();
		wb = edge_operand();
		pc = edge_operand();
		sel = 4'(n); // sweeps all sixteen bypass combinations
		long_op = (insn[31:27] == OP_RTYPE) && ((insn[6:2] == ALU_MUL) || (insn[6:2] == ALU_DIV));
		tag = $sformatf("txn %0d opcode %0d func %0d", n, insn[31:27], insn[6:2]);
		build_expected(insn, opa, opb, pc, xm, wb, sel);

		@(posedge clock);
		i_req <= 1'b1;
		i_insn <= insn;
		i_operand_a <= opa;
		i_operand_b <= opb;
		i_pc <= pc;
		i_xm_value <= xm;
		i_wb_value <= wb;
		i_mx_bypass_a <= sel[3];
		i_wx_bypass_a <= sel[2];
		i_mx_bypass_b <= sel[1];
		i_wx_bypass_b <= sel[0];

		wait_cycles = 0;
		do begin
			@(posedge clock);
			wait_cycles++;
			@(negedge clock); // outputs settled here
		end while (!o_ack);
		if (!long_op)
			compare_word({tag, " ack latency"}, 32'd3, 32'(wait_cycles)); // sample edge plus two
		compare_outputs(tag);

		hold = $urandom_range(0, 5);
		repeat (hold) begin
			@(negedge clock);
			assert (o_ack) else begin
				other_failures++;
				$display("%s: ack dropped while the request was still high", tag);
			end
			compare_outputs({tag, " held"});
		end

		@(posedge clock);
		i_req <= 1'b0;
		wait_cycles = 0;
		do begin
			@(posedge clock);
			wait_cycles++;
			@(negedge clock);
		end while (o_ack);
		compare_word({tag, " release latency"}, 32'd1, 32'(wait_cycles));
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout, the DUT stopped answering requests");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		void'($urandom(58));
		i_rst_n <= 1'b0;
		i_req <= 1'b0;
		i_insn <= '0;
		i_operand_a <= '0;
		i_operand_b <= '0;
		i_pc <= '0;
		i_mx_bypass_a <= 1'b0;
		i_wx_bypass_a <= 1'b0;
		i_mx_bypass_b <= 1'b0;
		i_wx_bypass_b <= 1'b0;
		i_xm_value <= '0;
		i_wb_value <= '0;
		repeat (8) @(posedge clock);
		i_rst_n <= 1'b1;
		@(negedge clock);
		compare_word("reset o_ack", 32'd0, {31'b0, o_ack});
		compare_word("reset o_result", 32'd0, o_result);
		compare_word("reset o_b_value", 32'd0, o_b_value);
		compare_word("reset o_write_exception", 32'd0, {31'b0, o_write_exception});
		compare_word("reset o_next_pc", 32'd0, o_next_pc);
		compare_word("reset o_taken", 32'd0, {31'b0, o_taken});

		for (int n = 0; n < NUM_TXN; n++)
			run_transaction(n);

		total_errors = mismatches + other_failures + int'(UUT.u_asserts.failures);
		$display("summary: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, other_failures, UUT.u_asserts.failures);
		if (total_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/isa_pkg.sv
rtl/insn_decode.sv
rtl/alu.sv
rtl/muldiv.sv
rtl/stage_execute.sv
rtl/result_handshake.sv
rtl/exec_unit_top.sv
tests/exec_unit_asserts.sv
tests/exec_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
